// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps --top-module tb_exu -f sources.f
	./obj_dir/Vtb_exu > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sources.f
verilog/exu_pkg.sv
verilog/exu_regfile.sv
verilog/exu_bypass.sv
verilog/exu_alu.sv
verilog/exu_branch.sv
verilog/exu_pipe.sv
verilog/exu_top.sv
testbench/tb_exu.sv

// File: testbench/exu_patterns.txt
// vld pc rs1 rs2 rd wen imm alu_vld alu_op a_pc b_imm bru_vld bru_op offset
// then exp_wen exp_rd exp_data exp_taken exp_target test, all hex
1 100 00 00 01 1 12345678 1 a 0 1 0 0 0   1 01 12345678 0 0   2
1 104 00 00 02 1 f0f0000f 1 a 0 1 0 0 0   1 02 f0f0000f 0 0   2
1 108 00 00 03 1 fffffff8 1 a 0 1 0 0 0   1 03 fffffff8 0 0   2
1 10c 01 02 04 1 0        1 0 0 0 0 0 0   1 04 03245687 0 0   2
1 110 01 02 05 1 0        1 1 0 0 0 0 0   1 05 21445669 0 0   2
1 114 01 02 06 1 0        1 2 0 0 0 0 0   1 06 10300008 0 0   2
1 118 01 00 07 1 ff00     1 3 0 1 0 0 0   1 07 1234ff78 0 0   2
1 11c 01 02 08 1 0        1 4 0 0 0 0 0   1 08 e2c45677 0 0   2
1 120 03 01 09 1 0        1 5 0 0 0 0 0   1 09 1        0 0   2
1 124 03 01 0a 1 0        1 6 0 0 0 0 0   1 0a 0        0 0   2
1 128 01 00 0b 1 4        1 7 0 1 0 0 0   1 0b 23456780 0 0   2
1 12c 03 00 0c 1 4        1 8 0 1 0 0 0   1 0c 0fffffff 0 0   2
1 130 03 00 0d 1 4        1 9 0 1 0 0 0   1 0d ffffffff 0 0   2
1 134 00 00 0e 1 20       1 0 1 1 0 0 0   1 0e 154      0 0   2
1 138 02 09 0f 1 0        1 9 0 0 0 0 0   1 0f f8780007 0 0   2
1 13c 00 00 10 1 100      1 a 0 1 0 0 0   1 10 100      0 0   3
1 140 10 00 11 1 1        1 0 0 1 0 0 0   1 11 101      0 0   3
1 144 10 00 12 1 2        1 0 0 1 0 0 0   1 12 102      0 0   3
1 148 10 10 13 1 0        1 0 0 0 0 0 0   1 13 200      0 0   3
1 14c 10 00 14 1 4        1 0 0 1 0 0 0   1 14 104      0 0   3
1 150 00 00 16 1 aaaa     1 a 0 1 0 0 0   1 16 aaaa     0 0   3
1 154 00 00 16 1 bbbb     1 a 0 1 0 0 0   1 16 bbbb     0 0   3
1 158 16 00 17 1 0        1 0 0 1 0 0 0   1 17 bbbb     0 0   3
1 15c 00 00 00 1 deadbeef 1 a 0 1 0 0 0   1 00 deadbeef 0 0   4
1 160 00 00 18 1 5        1 0 0 1 0 0 0   1 18 5        0 0   4
1 164 00 00 19 1 0        1 3 0 0 0 0 0   1 19 0        0 0   4
1 168 10 10 00 0 0        0 0 0 0 1 0 40  0 00 0        1 1a8 5
1 16c 00 00 1a 1 11       1 a 0 1 0 0 0   0 00 0        0 0   5
1 170 00 00 1a 1 22       1 a 0 1 0 0 0   0 00 0        0 0   5
1 174 1a 00 1b 1 33       1 0 0 1 0 0 0   0 00 0        0 0   5
1 178 00 00 1c 1 0        0 0 0 0 1 6 100 1 1c 17c      1 278 5
1 17c 00 00 1b 1 0        0 0 0 0 1 6 8   0 00 0        0 0   5
1 180 00 00 1a 1 44       1 a 0 1 0 0 0   0 00 0        0 0   5
1 184 1a 00 1a 1 1        1 0 0 1 0 0 0   0 00 0        0 0   5
1 188 1c 00 1d 1 0        0 0 0 0 1 7 20  1 1d 18c      1 19c 5
1 18c 00 00 1a 1 55       1 a 0 1 0 0 0   0 00 0        0 0   5
1 190 00 00 1a 1 66       1 a 0 1 0 0 0   0 00 0        0 0   5
1 194 1d 00 1a 1 0        1 0 0 1 0 0 0   0 00 0        0 0   5
1 198 1d 00 1e 1 0        1 0 0 1 0 0 0   1 1e 18c      0 0   5
1 19c 10 11 00 0 0        0 0 0 0 1 0 40  0 00 0        0 0   6
1 1a0 10 10 00 0 0        0 0 0 0 1 1 40  0 00 0        0 0   6
1 1a4 01 03 00 0 0        0 0 0 0 1 2 40  0 00 0        0 0   6
1 1a8 03 01 00 0 0        0 0 0 0 1 3 40  0 00 0        0 0   6
1 1ac 03 01 00 0 0        0 0 0 0 1 4 40  0 00 0        0 0   6
1 1b0 01 03 00 0 0        0 0 0 0 1 5 40  0 00 0        0 0   6
1 1b4 10 00 1f 1 10       1 0 0 1 0 0 0   1 1f 110      0 0   6

// File: testbench/tb_exu.sv
`default_nettype none

module tb_exu;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int FIELDS    = 20;
   localparam int MAX_SLOTS = 256;
   localparam int PERIOD    = 40;
   localparam int LATENCY   = 3;

   logic               clk = 1'b0;
   logic               rst;
   logic               issue_vld;
   exu_pkg::issue_t    issue;
   exu_pkg::wb_t       wb;
   exu_pkg::redirect_t redirect;

   // one slot per FIELDS words, column order as in the pattern file
   logic [31:0] pat [MAX_SLOTS*FIELDS];
   int          nslot;
   int          errors;
   int          test_errors;
   int          cur_test;
   int          tests_passed;
   int          tests_failed;
   bit          loaded;

   exu_top u_dut (
      .clk       (clk),
      .rst       (rst),
      .issue_vld (issue_vld),
      .issue     (issue),
      .wb        (wb),
      .redirect  (redirect)
   );

   always #(PERIOD/2) clk = ~clk;

   function automatic logic [31:0] slot_field(input int s, input int idx);
      return pat[s*FIELDS + idx];
   endfunction

   task automatic flag_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
   endtask

   task automatic close_test();
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0d passed", cur_test);
      end else begin
         tests_failed++;
         $display("test %0d failed with %0d bad checks", cur_test, test_errors);
      end
      test_errors = 0;
   endtask

   // slots past the end of the file are idle
   task automatic drive_slot(input int s);
      exu_pkg::issue_t nxt;
      logic [31:0]     op_alu;
      logic [31:0]     op_bru;
      nxt = '0;
      issue_vld = 1'b0;
      if (s < nslot) begin
         op_alu      = slot_field(s, 8);
         op_bru      = slot_field(s, 12);
         issue_vld   = slot_field(s, 0) != 32'd0;
         nxt.pc      = slot_field(s, 1);
         nxt.rs1     = exu_pkg::reg_addr_t'(slot_field(s, 2));
         nxt.rs2     = exu_pkg::reg_addr_t'(slot_field(s, 3));
         nxt.rd      = exu_pkg::reg_addr_t'(slot_field(s, 4));
         nxt.wen     = slot_field(s, 5) != 32'd0;
         nxt.imm     = slot_field(s, 6);
         nxt.alu_vld = slot_field(s, 7) != 32'd0;
         nxt.alu_op  = exu_pkg::alu_op_t'(op_alu[3:0]);
         nxt.a_pc    = slot_field(s, 9) != 32'd0;
         nxt.b_imm   = slot_field(s, 10) != 32'd0;
         nxt.bru_vld = slot_field(s, 11) != 32'd0;
         nxt.bru_op  = exu_pkg::bru_op_t'(op_bru[3:0]);
         nxt.offset  = slot_field(s, 13);
      end
      issue = nxt;
   endtask

   // pipeline still empty right after reset
   task automatic check_idle(input int step);
      if (wb.wen !== 1'b0) begin
         flag_mismatch($sformatf("reset cycle %0d wb.wen", step), 32'(wb.wen), 32'd0);
      end
      if (redirect.taken !== 1'b0) begin
         flag_mismatch($sformatf("reset cycle %0d redirect.taken", step),
                       32'(redirect.taken), 32'd0);
      end
   endtask

   task automatic check_slot(input int s);
      logic [31:0] exp_wen;
      logic [31:0] exp_rd;
      logic [31:0] exp_data;
      logic [31:0] exp_taken;
      logic [31:0] exp_target;
      int          tnum;
      exp_wen    = slot_field(s, 14);
      exp_rd     = slot_field(s, 15);
      exp_data   = slot_field(s, 16);
      exp_taken  = slot_field(s, 17);
      exp_target = slot_field(s, 18);
      tnum       = int'(slot_field(s, 19));
      if (tnum != cur_test) begin
         close_test();
         cur_test = tnum;
      end
      if (wb.wen !== exp_wen[0]) begin
         flag_mismatch($sformatf("slot %0d wb.wen", s), 32'(wb.wen), exp_wen);
      end
      // rd and data only matter for a real write
      if (exp_wen[0] && (wb.rd !== exp_rd[4:0])) begin
         flag_mismatch($sformatf("slot %0d wb.rd", s), 32'(wb.rd), exp_rd);
      end
      if (exp_wen[0] && (wb.data !== exp_data)) begin
         flag_mismatch($sformatf("slot %0d wb.data", s), wb.data, exp_data);
      end
      if (redirect.taken !== exp_taken[0]) begin
         flag_mismatch($sformatf("slot %0d redirect.taken", s),
                       32'(redirect.taken), exp_taken);
      end
      if (exp_taken[0] && (redirect.target !== exp_target)) begin
         flag_mismatch($sformatf("slot %0d redirect.target", s),
                       redirect.target, exp_target);
      end
   endtask

   initial begin
      rst           = 1'b1;
      // a writing jump held at the input for the whole reset
      issue_vld     = 1'b1;
      issue         = '0;
      issue.rd      = exu_pkg::reg_addr_t'(1);
      issue.wen     = 1'b1;
      issue.bru_vld = 1'b1;
      issue.bru_op  = exu_pkg::bru_jump_pc;
      issue.offset  = 32'h40;
      errors        = 0;
      test_errors   = 0;
      cur_test      = 1;
      tests_passed  = 0;
      tests_failed  = 0;
      for (int j = 0; j < MAX_SLOTS*FIELDS; j++) begin
         pat[j] = {16'hdead, j[15:0]};
      end
      $readmemh("testbench/exu_patterns.txt", pat);
      // a valid column above 1 marks the first unused slot
      nslot = 0;
      while ((nslot < MAX_SLOTS) && (pat[nslot*FIELDS] <= 32'd1)) begin
         nslot++;
      end
      loaded = 1'b1;
      if (nslot == 0) begin
         $display("no patterns found in testbench/exu_patterns.txt");
         errors++;
      end else begin
         repeat (3) @(posedge clk);
         @(negedge clk);
         rst       = 1'b0;
         issue_vld = 1'b0;
         issue     = '0;
         // check the slot issued three cycles ago, then drive the next one
         for (int i = 0; i < nslot + LATENCY; i++) begin
            @(negedge clk);
            if (i < LATENCY) begin
               check_idle(i);
            end else begin
               check_slot(i - LATENCY);
            end
            drive_slot(i);
         end
         close_test();
      end
      $display("tests passed %0d, tests failed %0d, bad checks %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      wait (loaded);
      #((nslot + 10) * PERIOD);
      $display("watchdog expired, the run timed out");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/exu_alu.sv
`default_nettype none

module exu_alu (
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   rs1_val,
   input  exu_pkg::word_t   rs2_val,
   input  exu_pkg::word_t   imm,
   input  logic             a_pc,
   input  logic             b_imm,
   input  exu_pkg::alu_op_t op,
   output exu_pkg::word_t   result
);

   exu_pkg::word_t a;
   exu_pkg::word_t b;
   logic [4:0]     shamt;
   logic           lt_s;
   logic           lt_u;

   // operand select
   assign a     = a_pc  ? pc  : rs1_val;
   assign b     = b_imm ? imm : rs2_val;
   assign shamt = b[4:0];

   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         exu_pkg::alu_add:    result = a + b;
         exu_pkg::alu_sub:    result = a - b;
         exu_pkg::alu_and:    result = a & b;
         exu_pkg::alu_or:     result = a | b;
         exu_pkg::alu_xor:    result = a ^ b;
         exu_pkg::alu_slt: begin
            result = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
         end
         exu_pkg::alu_sltu: begin
            result = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
         end
         exu_pkg::alu_sll:    result = a << shamt;
         exu_pkg::alu_srl:    result = a >> shamt;
         // arithmetic shift keeps the sign
         exu_pkg::alu_sra:    result = exu_pkg::word_t'($signed(a) >>> shamt);
         exu_pkg::alu_pass_b: result = b;
         default:             result = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/exu_branch.sv
`default_nettype none

module exu_branch (
   input  logic             vld,
   input  exu_pkg::bru_op_t op,
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   rs1_val,
   input  exu_pkg::word_t   rs2_val,
   input  exu_pkg::word_t   offset,
   output logic             taken,
   output exu_pkg::word_t   target,
   output exu_pkg::word_t   link
);

   logic           eq;
   logic           lt_s;
   logic           lt_u;
   logic           cond;
   exu_pkg::word_t base;

   assign eq   = rs1_val == rs2_val;
   assign lt_s = $signed(rs1_val) < $signed(rs2_val);
   assign lt_u = rs1_val < rs2_val;

   always_comb begin
      case (op)
         exu_pkg::bru_beq:      cond = eq;
         exu_pkg::bru_bne:      cond = ~eq;
         exu_pkg::bru_blt:      cond = lt_s;
         exu_pkg::bru_bge:      cond = ~lt_s;
         exu_pkg::bru_bltu:     cond = lt_u;
         exu_pkg::bru_bgeu:     cond = ~lt_u;
         // jumps always go
         exu_pkg::bru_jump_pc:  cond = 1'b1;
         exu_pkg::bru_jump_reg: cond = 1'b1;
         default:               cond = 1'b0;
      endcase
   end

   assign taken = vld & cond;

   // register-relative only for jump_reg
   assign base   = (op == exu_pkg::bru_jump_reg) ? rs1_val : pc;
   assign target = base + offset;
   assign link   = pc + exu_pkg::word_t'(4);

endmodule

`default_nettype wire

// File: verilog/exu_bypass.sv
`default_nettype none

module exu_bypass (
   input  exu_pkg::reg_addr_t rs1,
   input  exu_pkg::reg_addr_t rs2,
   input  exu_pkg::word_t    rs1_data,
   input  exu_pkg::word_t    rs2_data,
   input  exu_pkg::wb_t      wr_m,
   input  exu_pkg::wb_t      wr_w,
   output exu_pkg::word_t    op_a,
   output exu_pkg::word_t    op_b
);

   // newest producer wins, m is younger than w
   function automatic exu_pkg::word_t fwd(
      input exu_pkg::reg_addr_t rs,
      input exu_pkg::word_t     rf_val,
      input exu_pkg::wb_t       m,
      input exu_pkg::wb_t       w
   );
      logic hit_m;
      logic hit_w;
      hit_m = m.wen && (m.rd != '0) && (m.rd == rs);
      hit_w = w.wen && (w.rd != '0) && (w.rd == rs);
      if (hit_m) begin
         return m.data;
      end else if (hit_w) begin
         return w.data;
      end
      return rf_val;
   endfunction

   assign op_a = fwd(rs1, rs1_data, wr_m, wr_w);
   assign op_b = fwd(rs2, rs2_data, wr_m, wr_w);

endmodule

`default_nettype wire

// File: verilog/exu_pipe.sv
`default_nettype none

module exu_pipe (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_vld,
   input  exu_pkg::issue_t    issue,
   input  exu_pkg::word_t     rs1_data,
   input  exu_pkg::word_t     rs2_data,
   input  exu_pkg::word_t     op_a,
   input  exu_pkg::word_t     op_b,
   input  exu_pkg::word_t     alu_result,
   input  logic               bru_taken,
   input  exu_pkg::word_t     bru_target,
   input  exu_pkg::word_t     bru_link,
   output exu_pkg::issue_t    ex,
   output exu_pkg::word_t     rs1_data_e,
   output exu_pkg::word_t     rs2_data_e,
   output exu_pkg::wb_t       wr_m,
   output exu_pkg::wb_t       wr_w,
   output exu_pkg::redirect_t redirect
);

   logic               flush;
   logic               accept;
   exu_pkg::word_t     result_e;
   exu_pkg::redirect_t redir_m;

   // a taken branch anywhere in e, m or w kills the slot at d
   assign flush  = bru_taken | redir_m.taken | redirect.taken;
   assign accept = issue_vld & ~flush;

   // e stage
   always_ff @(posedge clk) begin
      ex         <= issue;
      rs1_data_e <= rs1_data;
      rs2_data_e <= rs2_data;
      if (rst) begin
         ex.wen     <= 1'b0;
         ex.alu_vld <= 1'b0;
         ex.bru_vld <= 1'b0;
      end else begin
         ex.wen     <= accept & issue.wen;
         ex.alu_vld <= accept & issue.alu_vld;
         ex.bru_vld <= accept & issue.bru_vld;
      end
   end

   // branches write the link address
   assign result_e = ex.bru_vld ? bru_link : alu_result;

   // m stage
   always_ff @(posedge clk) begin
      wr_m.rd        <= ex.rd;
      wr_m.data      <= result_e;
      redir_m.target <= bru_target;
      if (rst) begin
         wr_m.wen      <= 1'b0;
         redir_m.taken <= 1'b0;
      end else begin
         wr_m.wen      <= ex.wen;
         redir_m.taken <= bru_taken;
      end
   end

   // w stage, drives the regfile write port and the redirect
   always_ff @(posedge clk) begin
      wr_w.rd         <= wr_m.rd;
      wr_w.data       <= wr_m.data;
      redirect.target <= redir_m.target;
      if (rst) begin
         wr_w.wen       <= 1'b0;
         redirect.taken <= 1'b0;
      end else begin
         wr_w.wen       <= wr_m.wen;
         redirect.taken <= redir_m.taken;
      end
   end

   a_one_unit : assert property (@(posedge clk) disable iff (rst)
      !(ex.alu_vld && ex.bru_vld))
      else $error("alu and bru both valid in e");

   a_taken_vld : assert property (@(posedge clk) disable iff (rst)
      bru_taken |-> ex.bru_vld)
      else $error("branch taken without a valid branch in e");

   // r0 stays zero through regfile and bypass, whatever m and w hold
   a_r0_operand : assert property (@(posedge clk) disable iff (rst)
      ((ex.rs1 == '0) |-> (op_a == '0)) and ((ex.rs2 == '0) |-> (op_b == '0)))
      else $error("register 0 operand is not zero");

endmodule

`default_nettype wire

// File: verilog/exu_pkg.sv
`default_nettype none

package exu_pkg;

   // widths fixed by the ISA
   localparam int XLEN = 32;
   localparam int NREG = 32;

   typedef logic [XLEN-1:0]        word_t;
   typedef logic [$clog2(NREG)-1:0] reg_addr_t;

   // integer ALU operations
   typedef enum logic [3:0] {
      alu_add    = 4'd0,
      alu_sub    = 4'd1,
      alu_and    = 4'd2,
      alu_or     = 4'd3,
      alu_xor    = 4'd4,
      alu_slt    = 4'd5,
      alu_sltu   = 4'd6,
      alu_sll    = 4'd7,
      alu_srl    = 4'd8,
      alu_sra    = 4'd9,
      alu_pass_b = 4'd10
   } alu_op_t;

   // compare branches, then the two jump forms
   typedef enum logic [3:0] {
      bru_beq      = 4'd0,
      bru_bne      = 4'd1,
      bru_blt      = 4'd2,
      bru_bge      = 4'd3,
      bru_bltu     = 4'd4,
      bru_bgeu     = 4'd5,
      bru_jump_pc  = 4'd6,
      bru_jump_reg = 4'd7
   } bru_op_t;

   // one issued instruction
   typedef struct packed {
      word_t     pc;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      logic      wen;
      word_t     imm;
      logic      alu_vld;
      alu_op_t   alu_op;
      logic      a_pc;
      logic      b_imm;
      logic      bru_vld;
      bru_op_t   bru_op;
      word_t     offset;
   } issue_t;

   // one register file write
   typedef struct packed {
      logic      wen;
      reg_addr_t rd;
      word_t     data;
   } wb_t;

   // fetch redirect
   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

endpackage

`default_nettype wire

// File: verilog/exu_regfile.sv
`default_nettype none

module exu_regfile (
   input  logic              clk,
   input  logic              rst,
   input  exu_pkg::reg_addr_t raddr1,
   input  exu_pkg::reg_addr_t raddr2,
   output exu_pkg::word_t    rdata1,
   output exu_pkg::word_t    rdata2,
   input  exu_pkg::wb_t      wr
);

   exu_pkg::word_t regs [exu_pkg::NREG];
   logic           wr_live;

   // r0 is never a real write target
   assign wr_live = wr.wen & (wr.rd != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < exu_pkg::NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // write-through so a read in the write cycle sees the new value
   assign rdata1 = (raddr1 == '0)                  ? '0      :
                   (wr_live && (wr.rd == raddr1))  ? wr.data :
                                                     regs[raddr1];
   assign rdata2 = (raddr2 == '0)                  ? '0      :
                   (wr_live && (wr.rd == raddr2))  ? wr.data :
                                                     regs[raddr2];

   // a write aimed at r0 must leave the stored zero alone
   a_r0_zero : assert property (@(posedge clk) disable iff (rst)
      (wr.wen && (wr.rd == '0)) |=> (regs[0] == '0))
      else $error("register 0 was overwritten");

endmodule

`default_nettype wire

// File: verilog/exu_top.sv
`default_nettype none

module exu_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_vld,
   input  exu_pkg::issue_t    issue,
   output exu_pkg::wb_t       wb,
   output exu_pkg::redirect_t redirect
);

   exu_pkg::word_t  rs1_data;
   exu_pkg::word_t  rs2_data;
   exu_pkg::issue_t ex;
   exu_pkg::word_t  rs1_data_e;
   exu_pkg::word_t  rs2_data_e;
   exu_pkg::wb_t    wr_m;
   exu_pkg::word_t  op_a;
   exu_pkg::word_t  op_b;
   exu_pkg::word_t  alu_result;
   logic            bru_taken;
   exu_pkg::word_t  bru_target;
   exu_pkg::word_t  bru_link;

   // read at d with the incoming source indices, written from w
   exu_regfile u_regfile (
      .clk    (clk),
      .rst    (rst),
      .raddr1 (issue.rs1),
      .raddr2 (issue.rs2),
      .rdata1 (rs1_data),
      .rdata2 (rs2_data),
      .wr     (wb)
   );

   exu_bypass u_bypass (
      .rs1      (ex.rs1),
      .rs2      (ex.rs2),
      .rs1_data (rs1_data_e),
      .rs2_data (rs2_data_e),
      .wr_m     (wr_m),
      .wr_w     (wb),
      .op_a     (op_a),
      .op_b     (op_b)
   );

   exu_alu u_alu (
      .pc      (ex.pc),
      .rs1_val (op_a),
      .rs2_val (op_b),
      .imm     (ex.imm),
      .a_pc    (ex.a_pc),
      .b_imm   (ex.b_imm),
      .op      (ex.alu_op),
      .result  (alu_result)
   );

   exu_branch u_branch (
      .vld     (ex.bru_vld),
      .op      (ex.bru_op),
      .pc      (ex.pc),
      .rs1_val (op_a),
      .rs2_val (op_b),
      .offset  (ex.offset),
      .taken   (bru_taken),
      .target  (bru_target),
      .link    (bru_link)
   );

   exu_pipe u_pipe (
      .clk        (clk),
      .rst        (rst),
      .issue_vld  (issue_vld),
      .issue      (issue),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .op_a       (op_a),
      .op_b       (op_b),
      .alu_result (alu_result),
      .bru_taken  (bru_taken),
      .bru_target (bru_target),
      .bru_link   (bru_link),
      .ex         (ex),
      .rs1_data_e (rs1_data_e),
      .rs2_data_e (rs2_data_e),
      .wr_m       (wr_m),
      .wr_w       (wb),
      .redirect   (redirect)
   );

endmodule

`default_nettype wire
